// ==== hdl/icache_bram.sv ====
// Single port, read-first: a write cycle returns the old word; contents have no reset
module icache_bram
  import icache_pkg::*;
#(
  parameter int DATA_W = 8,
  parameter int DEPTH  = NUM_SET
) (
  input  logic              clk_i,
  input  idx_t              addr_i,
  input  logic              wr_en_i,
  input  logic [DATA_W-1:0] wr_data_i,
  output logic [DATA_W-1:0] rd_data_o
);

  // Storage, one word per set
  logic [DATA_W-1:0] mem_q [DEPTH];

  // Write port
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[addr_i] <= wr_data_i;
    end
  end

  // Read port, data one cycle after the address
  always_ff @(posedge clk_i) begin
    rd_data_o <= mem_q[addr_i];
  end

endmodule

// ==== hdl/icache_ctrl.sv ====
// Request after a cached fill re-reads the arrays for one cycle; flush_i ignored during a sweep
module icache_ctrl
  import icache_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             req_valid_i,
  input  icache_addr_u     req_addr_i,
  input  logic             req_uncached_i,
  input  logic             pipe_ready_i,
  input  logic             hit_i,
  input  way_vec_t         hit_vec_i,
  input  blk_t             hit_blk_i,
  input  way_vec_t         victim_i,
  input  logic             mem_gnt_i,
  input  logic             mem_rsp_valid_i,
  input  blk_t             mem_rsp_blk_i,
  output idx_t             idx_o,
  output logic [TAG_W-1:0] req_tag_o,
  output logic             fill_o,
  output way_vec_t         fill_way_o,
  output blk_t             fill_blk_o,
  output logic             flush_active_o,
  output logic             plru_upd_o,
  output way_vec_t         access_way_o,
  output logic             res_valid_o,
  output logic             res_ready_o,
  output logic             res_miss_o,
  output blk_t             res_blk_o,
  output logic             mem_req_valid_o,
  output icache_addr_u     mem_req_addr_o,
  output logic             mem_req_uncached_o
);

  logic         flush_q;
  idx_t         flush_idx_q;
  logic         req_valid_q;
  icache_addr_u req_addr_q;
  logic         req_unc_q;
  logic         ack_q;
  logic         data_ok_q;
  logic         lookup;
  logic         hit;
  logic         miss;
  logic         rsp_done;
  logic         load;
  idx_t         rd_idx;

  // ========================================================================
  // Lookup state
  // ========================================================================

  // Array output belongs to the registered request
  assign lookup   = req_valid_q && data_ok_q && !flush_q;
  assign hit      = lookup && hit_i;
  assign miss     = lookup && !hit_i;
  // Memory answer for the pending miss
  assign rsp_done = miss && mem_rsp_valid_i;

  // Not ready while sweeping, re-reading or waiting on memory
  assign res_ready_o = !flush_q && !(req_valid_q && !data_ok_q) && (!miss || mem_rsp_valid_i);
  assign load        = res_ready_o && pipe_ready_i;

  // Read the incoming set when the register frees up, so hits stream
  assign rd_idx = (!req_valid_q || load) ? req_addr_i.f.idx : req_addr_q.f.idx;
  // Writes win the single array port
  assign idx_o  = flush_q ? flush_idx_q : (fill_o ? req_addr_q.f.idx : rd_idx);

  // ========================================================================
  // Array and PLRU controls
  // ========================================================================

  // Uncached lines are never allocated
  assign fill_o         = rsp_done && !req_unc_q;
  assign fill_way_o     = victim_i;
  assign fill_blk_o     = mem_rsp_blk_i;
  assign req_tag_o      = req_addr_q.f.tag;
  assign flush_active_o = flush_q;
  // Touch on delivered hits and on allocations
  assign plru_upd_o     = (hit && pipe_ready_i) || fill_o;
  assign access_way_o   = hit ? hit_vec_i : victim_i;

  // ========================================================================
  // Response and memory side
  // ========================================================================

  assign res_valid_o        = pipe_ready_i && (hit || rsp_done);
  assign res_miss_o         = miss;
  assign res_blk_o          = rsp_done ? mem_rsp_blk_i : hit_blk_i;
  // Held until granted, then quiet until the response
  assign mem_req_valid_o    = miss && !ack_q;
  assign mem_req_addr_o     = req_addr_q;
  assign mem_req_uncached_o = req_unc_q;

  // Request register; a sweep drops whatever it holds
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (flush_q) begin
      req_valid_q <= 1'b0;
    end else if (load) begin
      req_valid_q <= req_valid_i;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (load && req_valid_i) begin
      req_addr_q <= req_addr_i;
      req_unc_q  <= req_uncached_i;
    end
  end

  // Array data goes stale after any write cycle
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      data_ok_q <= 1'b0;
    end else begin
      data_ok_q <= !(flush_q || fill_o);
    end
  end

  // Grant seen, response still due
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (mem_rsp_valid_i) begin
      ack_q <= 1'b0;
    end else if (mem_req_valid_o && mem_gnt_i) begin
      ack_q <= 1'b1;
    end
  end

  // Sweep, one set per cycle, also started by reset
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      flush_q     <= 1'b1;
      flush_idx_q <= '0;
    end else if (flush_q) begin
      if (flush_idx_q == idx_t'(NUM_SET - 1)) begin
        flush_q     <= 1'b0;
        flush_idx_q <= '0;
      end else begin
        flush_idx_q <= flush_idx_q + idx_t'(1);
      end
    end else begin
      flush_q <= flush_i;
    end
  end

  // Request and address stay put until the memory grants
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_gnt_i && !mem_rsp_valid_i && !flush_i
    |=> mem_req_valid_o && $stable(mem_req_addr_o))
    else $error("Memory request dropped before grant");

endmodule

// ==== hdl/icache_pkg.sv ====
// Derived widths follow the macros; capacity / line / ways must be a power of two >= 2
`include "icache_params.svh"

package icache_pkg;

  // ========================================================================
  // Geometry
  // ========================================================================

  localparam int XLEN    = `ICACHE_XLEN;
  localparam int BLK_W   = `ICACHE_BLK_BITS;
  localparam int NUM_WAY = `ICACHE_NUM_WAY;
  localparam int NUM_SET = `ICACHE_SIZE_BITS / `ICACHE_BLK_BITS / `ICACHE_NUM_WAY;

  // Field widths of a fetch address
  localparam int IDX_W = $clog2(NUM_SET);
  localparam int OFF_W = $clog2(BLK_W / 8);
  localparam int TAG_W = XLEN - IDX_W - OFF_W;

  // ========================================================================
  // Types
  // ========================================================================

  typedef logic [BLK_W-1:0]   blk_t;
  typedef logic [NUM_WAY-1:0] way_vec_t;
  // Tree bits in heap order, node 0 is the root
  typedef logic [NUM_WAY-2:0] node_t;
  typedef logic [IDX_W-1:0]   idx_t;

  // Same word seen as a flat address or split for lookup
  typedef union packed {
    logic [XLEN-1:0] raw;
    struct packed {
      logic [TAG_W-1:0] tag;
      idx_t             idx;
      logic [OFF_W-1:0] off;
    } f;
  } icache_addr_u;

endpackage

// ==== hdl/icache_plru.sv ====
// Tree PLRU; an update is skipped when the node read under it was overwritten last cycle
module icache_plru
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  idx_t     idx_i,
  input  logic     upd_i,
  input  way_vec_t access_way_i,
  input  logic     flush_active_i,
  output way_vec_t victim_o
);

  localparam int LVLS = $clog2(NUM_WAY);

  node_t node_rd;
  node_t node_wr;
  idx_t  node_addr;
  idx_t  rd_idx_q;
  logic  node_ok_q;
  logic  upd_ok;
  logic  node_we;

  // Walk from the root, bit set means take the right child
  function automatic way_vec_t pick_victim(input node_t n);
    way_vec_t    v;
    int unsigned k;
    v = '0;
    k = 0;
    for (int lvl = 0; lvl < LVLS; lvl++) begin
      k = 2 * k + 1 + n[k];
    end
    v[k-(NUM_WAY-1)] = 1'b1;
    return v;
  endfunction

  // Climb from the leaf, each parent now points at the other subtree
  function automatic node_t touch(input node_t n, input way_vec_t w);
    node_t       r;
    int unsigned k;
    int unsigned p;
    r = n;
    k = NUM_WAY - 1;
    for (int i = 0; i < NUM_WAY; i++) begin
      if (w[i]) k = NUM_WAY - 1 + i;
    end
    for (int lvl = 0; lvl < LVLS; lvl++) begin
      p    = (k - 1) / 2;
      // Came from the left child -> point right
      r[p] = (k == 2 * p + 1);
      k    = p;
    end
    return r;
  endfunction

  // Write back at the set whose nodes are on the read port
  assign upd_ok    = upd_i && node_ok_q && !flush_active_i;
  assign node_we   = flush_active_i || upd_ok;
  assign node_addr = upd_ok ? rd_idx_q : idx_i;
  assign node_wr   = flush_active_i ? '0 : touch(node_rd, access_way_i);
  assign victim_o  = pick_victim(node_rd);

  icache_bram #(
    .DATA_W(NUM_WAY - 1),
    .DEPTH (NUM_SET)
  ) u_node (
    .clk_i    (clk_i),
    .addr_i   (node_addr),
    .wr_en_i  (node_we),
    .wr_data_i(node_wr),
    .rd_data_o(node_rd)
  );

  // Set of the current read data
  always_ff @(posedge clk_i) begin
    rd_idx_q <= node_addr;
  end

  // A write cycle leaves stale nodes on the read port
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      node_ok_q <= 1'b0;
    end else begin
      node_ok_q <= !node_we;
    end
  end

  // Access way comes from the hit vector or from the victim in ctrl
  a_access_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    upd_i |-> $onehot(access_way_i))
    else $error("PLRU access way not one-hot on update");

endmodule

// ==== hdl/icache_top.sv ====
// Read-only cache; res_ready_o stays low for NUM_SET cycles after reset and after flush_i
module icache_top
  import icache_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  input  logic         req_valid_i,
  input  icache_addr_u req_addr_i,
  input  logic         req_uncached_i,
  input  logic         pipe_ready_i,
  output logic         res_valid_o,
  output logic         res_ready_o,
  output logic         res_miss_o,
  output blk_t         res_blk_o,
  output logic         mem_req_valid_o,
  output icache_addr_u mem_req_addr_o,
  output logic         mem_req_uncached_o,
  input  logic         mem_gnt_i,
  input  logic         mem_rsp_valid_i,
  input  blk_t         mem_rsp_blk_i
);

  // Ctrl to arrays
  idx_t             idx;
  logic [TAG_W-1:0] req_tag;
  logic             fill;
  way_vec_t         fill_way;
  blk_t             fill_blk;
  logic             flush_active;
  logic             plru_upd;
  way_vec_t         access_way;
  // Arrays to ctrl
  logic             hit;
  way_vec_t         hit_vec;
  blk_t             hit_blk;
  way_vec_t         victim;

  icache_ctrl u_ctrl (
    .clk_i, .rst_ni, .flush_i, .req_valid_i, .req_addr_i, .req_uncached_i, .pipe_ready_i,
    .hit_i(hit), .hit_vec_i(hit_vec), .hit_blk_i(hit_blk), .victim_i(victim),
    .mem_gnt_i, .mem_rsp_valid_i, .mem_rsp_blk_i,
    .idx_o(idx), .req_tag_o(req_tag), .fill_o(fill), .fill_way_o(fill_way),
    .fill_blk_o(fill_blk), .flush_active_o(flush_active), .plru_upd_o(plru_upd),
    .access_way_o(access_way),
    .res_valid_o, .res_ready_o, .res_miss_o, .res_blk_o,
    .mem_req_valid_o, .mem_req_addr_o, .mem_req_uncached_o
  );

  icache_ways u_ways (
    .clk_i, .idx_i(idx), .req_tag_i(req_tag), .fill_i(fill), .fill_way_i(fill_way),
    .fill_blk_i(fill_blk), .flush_active_i(flush_active),
    .hit_o(hit), .hit_vec_o(hit_vec), .hit_blk_o(hit_blk)
  );

  icache_plru u_plru (
    .clk_i, .rst_ni, .idx_i(idx), .upd_i(plru_upd), .access_way_i(access_way),
    .flush_active_i(flush_active), .victim_o(victim)
  );

endmodule

// ==== hdl/icache_ways.sv ====
// Lookup data is valid one cycle after idx_i; hit outputs are meaningless right after a write
module icache_ways
  import icache_pkg::*;
(
  input  logic             clk_i,
  input  idx_t             idx_i,
  input  logic [TAG_W-1:0] req_tag_i,
  input  logic             fill_i,
  input  way_vec_t         fill_way_i,
  input  blk_t             fill_blk_i,
  input  logic             flush_active_i,
  output logic             hit_o,
  output way_vec_t         hit_vec_o,
  output blk_t             hit_blk_o
);

  // ========================================================================
  // Arrays
  // ========================================================================

  // Tag entry is {valid, tag}
  logic [TAG_W:0] tag_wr;
  logic [TAG_W:0] tag_rd  [NUM_WAY];
  blk_t           data_rd [NUM_WAY];

  // Sweep writes all-zero, so the valid bit drops
  assign tag_wr = flush_active_i ? '0 : {1'b1, req_tag_i};

  for (genvar w = 0; w < NUM_WAY; w++) begin : gen_way
    logic data_we;
    logic tag_we;

    // Fill touches one way only
    assign data_we = fill_i && fill_way_i[w];
    // Sweep clears every way of the set
    assign tag_we  = flush_active_i || data_we;

    icache_bram #(
      .DATA_W(TAG_W + 1),
      .DEPTH (NUM_SET)
    ) u_tag (
      .clk_i    (clk_i),
      .addr_i   (idx_i),
      .wr_en_i  (tag_we),
      .wr_data_i(tag_wr),
      .rd_data_o(tag_rd[w])
    );

    // Line data, never cleared
    icache_bram #(
      .DATA_W(BLK_W),
      .DEPTH (NUM_SET)
    ) u_data (
      .clk_i    (clk_i),
      .addr_i   (idx_i),
      .wr_en_i  (data_we),
      .wr_data_i(fill_blk_i),
      .rd_data_o(data_rd[w])
    );
  end

  // ========================================================================
  // Compare and select
  // ========================================================================

  // Stored valid tag against the registered request tag
  always_comb begin
    for (int w = 0; w < NUM_WAY; w++) begin
      hit_vec_o[w] = tag_rd[w][TAG_W] && (tag_rd[w][TAG_W-1:0] == req_tag_i);
    end
  end

  assign hit_o = |hit_vec_o;

  // AND-OR mux; only the hitting way contributes
  always_comb begin
    hit_blk_o = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (hit_vec_o[w]) begin
        hit_blk_o = hit_blk_o | data_rd[w];
      end
    end
  end

  // Ctrl allocates only on a miss, so a line never sits in two ways
  a_hit_unique: assert property (@(posedge clk_i)
    !flush_active_i && !$past(flush_active_i) |-> $onehot0(hit_vec_o))
    else $error("More than one way hit");

endmodule

// ==== icache_top.f ====
+incdir+include
hdl/icache_pkg.sv
hdl/icache_bram.sv
hdl/icache_plru.sv
hdl/icache_ways.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

// ==== include/icache_params.svh ====
// Top-level cache geometry; NUM_WAY must be a power of two >= 2 and yield at least 2 sets
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// ==========================================================================
// Address and capacity
// ==========================================================================

// Fetch address width in bits
`define ICACHE_XLEN 32

// Total data capacity in bits, tags not counted
`define ICACHE_SIZE_BITS 8192

// ==========================================================================
// Line and associativity
// ==========================================================================

// One line, also the width of a lower-memory transfer
`define ICACHE_BLK_BITS 128

// Associativity
`define ICACHE_NUM_WAY 4

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Builds the cache testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
  --top-module icache_tb \
  -f icache_top.f \
  -o icache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/icache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// ==== testbench/icache_mem_model.sv ====
// Lower-memory model with one outstanding request; delays in cycles, 32-bit words per line assumed
module icache_mem_model
  import icache_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  int           gnt_delay_i,
  input  int           rsp_delay_i,
  input  logic         req_valid_i,
  input  icache_addr_u req_addr_i,
  output logic         gnt_o,
  output logic         rsp_valid_o,
  output blk_t         rsp_blk_o,
  output int           grant_cnt_o
);

  logic         busy_q;
  int           wait_q;
  icache_addr_u line_q;

  // Word w of a line is its line address ^ 32'ha5a5_0000 ^ w
  function automatic blk_t line_data(input icache_addr_u a);
    blk_t            b;
    logic [XLEN-1:0] base;
    base            = a.raw;
    base[OFF_W-1:0] = '0;
    for (int w = 0; w < BLK_W / 32; w++) begin
      b[32*w +: 32] = base ^ 32'ha5a5_0000 ^ 32'(w);
    end
    return b;
  endfunction

  // Quiet bus before the first clock edge
  initial begin
    gnt_o       = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_blk_o   = '0;
    grant_cnt_o = 0;
  end

  always @(posedge clk_i) begin
    gnt_o       <= 1'b0;
    rsp_valid_o <= 1'b0;
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      wait_q      <= 0;
      grant_cnt_o <= 0;
    end else if (!busy_q) begin
      // Grant once the request has been held for gnt_delay_i cycles
      if (req_valid_i) begin
        if (wait_q >= gnt_delay_i) begin
          gnt_o       <= 1'b1;
          line_q      <= req_addr_i;
          grant_cnt_o <= grant_cnt_o + 1;
          busy_q      <= 1'b1;
          wait_q      <= 0;
        end else begin
          wait_q <= wait_q + 1;
        end
      end
    end else if (wait_q >= rsp_delay_i) begin
      // One-cycle response pulse with the whole line
      rsp_valid_o <= 1'b1;
      rsp_blk_o   <= line_data(line_q);
      busy_q      <= 1'b0;
      wait_q      <= 0;
    end else begin
      wait_q <= wait_q + 1;
    end
  end

endmodule

// ==== testbench/icache_tb.sv ====
// Directed tests; assumes 4 ways and zeroed PLRU nodes in every set that a test first touches
module icache_tb
  import icache_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  // Tests take about 350 cycles, so 2000 leaves a wide margin
  localparam int RUN_LIMIT  = 2000 * CLK_PERIOD;

  logic         clk_i;
  logic         rst_ni;
  logic         flush_i;
  logic         req_valid_i;
  icache_addr_u req_addr_i;
  logic         req_uncached_i;
  logic         pipe_ready_i;
  logic         res_valid_o;
  logic         res_ready_o;
  logic         res_miss_o;
  blk_t         res_blk_o;
  logic         mem_req_valid_o;
  icache_addr_u mem_req_addr_o;
  logic         mem_req_uncached_o;
  logic         mem_gnt_i;
  logic         mem_rsp_valid_i;
  blk_t         mem_rsp_blk_i;
  int           gnt_delay;
  int           rsp_delay;
  int           grant_cnt;

  // Every line that ends up allocated, for the flush check
  icache_addr_u filled_q [$];

  icache_top DUT (
    .clk_i, .rst_ni, .flush_i, .req_valid_i, .req_addr_i, .req_uncached_i, .pipe_ready_i,
    .res_valid_o, .res_ready_o, .res_miss_o, .res_blk_o,
    .mem_req_valid_o, .mem_req_addr_o, .mem_req_uncached_o,
    .mem_gnt_i, .mem_rsp_valid_i, .mem_rsp_blk_i
  );

  icache_mem_model mem (
    .clk_i, .rst_ni, .gnt_delay_i(gnt_delay), .rsp_delay_i(rsp_delay),
    .req_valid_i(mem_req_valid_o), .req_addr_i(mem_req_addr_o),
    .gnt_o(mem_gnt_i), .rsp_valid_o(mem_rsp_valid_i), .rsp_blk_o(mem_rsp_blk_i),
    .grant_cnt_o(grant_cnt)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ==========================================================================
  // Compare helpers
  // ==========================================================================

  task automatic fail_now(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("TEST FAILED");
    $fatal(1, "Stopping at first failure");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic check_blk(input string name, input blk_t got, input blk_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic check_addr(input string name, input icache_addr_u got, input icache_addr_u exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got.raw, exp.raw);
      $display("TEST FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Memory fill pattern, built from the line address
  function automatic blk_t exp_blk(input icache_addr_u a);
    blk_t            b;
    logic [XLEN-1:0] base;
    base            = a.raw;
    base[OFF_W-1:0] = '0;
    for (int w = 0; w < BLK_W / 32; w++) begin
      b[32*w +: 32] = base ^ 32'ha5a5_0000 ^ 32'(w);
    end
    return b;
  endfunction

  // Random address in a given set; low tag bits keep lines of one test apart
  function automatic icache_addr_u pick_addr(input idx_t set, input int k);
    icache_addr_u a;
    a.raw        = $urandom;
    a.f.idx      = set;
    a.f.tag[3:0] = 4'(k);
    return a;
  endfunction

  // ==========================================================================
  // Bus-level tasks
  // ==========================================================================

  // Sweep: NUM_SET cycles not ready and silent, then ready
  task automatic expect_sweep();
    for (int i = 0; i < NUM_SET; i++) begin
      @(negedge clk_i);
      check_bit("res_ready_o", res_ready_o, 1'b0);
      check_bit("res_valid_o", res_valid_o, 1'b0);
      check_bit("res_miss_o", res_miss_o, 1'b0);
      check_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
    end
    @(negedge clk_i);
    check_bit("res_ready_o", res_ready_o, 1'b1);
  endtask

  // One fetch: wait for capture, then for the response
  task automatic fetch(input icache_addr_u addr, input logic unc,
                       output blk_t blk, output logic missed);
    @(posedge clk_i);
    #1;
    req_valid_i    = 1'b1;
    req_addr_i     = addr;
    req_uncached_i = unc;
    @(negedge clk_i);
    while (!res_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    missed      = 1'b0;
    @(negedge clk_i);
    while (!res_valid_o) begin
      missed = missed | res_miss_o;
      // Outgoing request carries the fetch address as captured
      if (mem_req_valid_o) begin
        check_addr("mem_req_addr_o", mem_req_addr_o, addr);
        check_bit("mem_req_uncached_o", mem_req_uncached_o, unc);
      end
      @(negedge clk_i);
    end
    missed = missed | res_miss_o;
    blk    = res_blk_o;
  endtask

  task automatic expect_fetch(input icache_addr_u addr, input logic unc, input logic exp_miss);
    blk_t blk;
    logic missed;
    fetch(addr, unc, blk, missed);
    check_bit("res_miss_o", missed, exp_miss);
    check_blk("res_blk_o", blk, exp_blk(addr));
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================

  task automatic first_fetch_miss_then_hit();
    icache_addr_u a;
    a = pick_addr(idx_t'(1), 0);
    expect_fetch(a, 1'b0, 1'b1);
    expect_fetch(a, 1'b0, 1'b0);
    filled_q.push_back(a);
  endtask

  // Back-to-back hits, each due one cycle after its capture
  task automatic stream_hits();
    icache_addr_u lines [4];
    int           seq [5];
    seq = '{0, 2, 1, 3, 0};
    for (int i = 0; i < 4; i++) begin
      lines[i] = pick_addr(idx_t'(2 + i / 2), i);
      expect_fetch(lines[i], 1'b0, 1'b1);
      filled_q.push_back(lines[i]);
    end
    @(posedge clk_i);
    #1;
    req_valid_i    = 1'b1;
    req_uncached_i = 1'b0;
    req_addr_i     = lines[seq[0]];
    for (int i = 0; i < 5; i++) begin
      @(negedge clk_i);
      check_bit("res_ready_o", res_ready_o, 1'b1);
      if (i > 0) begin
        check_bit("res_valid_o", res_valid_o, 1'b1);
        check_bit("res_miss_o", res_miss_o, 1'b0);
        check_blk("res_blk_o", res_blk_o, exp_blk(lines[seq[i-1]]));
      end
      @(posedge clk_i);
      #1;
      if (i < 4) begin
        req_addr_i = lines[seq[i+1]];
      end else begin
        req_valid_i = 1'b0;
      end
    end
    @(negedge clk_i);
    check_bit("res_valid_o", res_valid_o, 1'b1);
    check_blk("res_blk_o", res_blk_o, exp_blk(lines[seq[4]]));
  endtask

  task automatic plru_replacement();
    icache_addr_u l [5];
    for (int i = 0; i < 5; i++) begin
      l[i] = pick_addr(idx_t'(5), i);
    end
    for (int i = 0; i < 4; i++) begin
      expect_fetch(l[i], 1'b0, 1'b1);
    end
    expect_fetch(l[0], 1'b0, 1'b0);
    expect_fetch(l[4], 1'b0, 1'b1);
    // From cleared nodes A..D land in ways 0, 2, 1, 3
    // Touching A points the root at ways 2/3, and D left that node on way 2
    // So E takes way 2 and B is the line that goes
    expect_fetch(l[0], 1'b0, 1'b0);
    expect_fetch(l[2], 1'b0, 1'b0);
    expect_fetch(l[3], 1'b0, 1'b0);
    expect_fetch(l[4], 1'b0, 1'b0);
    expect_fetch(l[1], 1'b0, 1'b1);
    for (int i = 0; i < 5; i++) begin
      filled_q.push_back(l[i]);
    end
  endtask

  task automatic uncached_bypass();
    icache_addr_u u;
    u = pick_addr(idx_t'(7), 0);
    expect_fetch(u, 1'b1, 1'b1);
    // Not allocated, so the cached fetch misses too
    expect_fetch(u, 1'b0, 1'b1);
    expect_fetch(u, 1'b0, 1'b0);
    filled_q.push_back(u);
  endtask

  task automatic backpressure_slow_grant();
    icache_addr_u p;
    icache_addr_u q;
    int           g0;
    p         = pick_addr(idx_t'(9), 0);
    q         = pick_addr(idx_t'(9), 1);
    gnt_delay = 6;
    rsp_delay = 3;
    g0        = grant_cnt;
    expect_fetch(p, 1'b0, 1'b1);
    if (grant_cnt - g0 != 1) begin
      fail_now($sformatf("memory granted %0d requests for one miss", grant_cnt - g0));
    end
    // Miss captured, then the consumer stalls through the whole fill
    g0 = grant_cnt;
    @(posedge clk_i);
    #1;
    req_valid_i    = 1'b1;
    req_addr_i     = q;
    req_uncached_i = 1'b0;
    @(negedge clk_i);
    while (!res_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req_valid_i  = 1'b0;
    pipe_ready_i = 1'b0;
    repeat (30) begin
      @(negedge clk_i);
      check_bit("res_valid_o", res_valid_o, 1'b0);
    end
    if (grant_cnt - g0 != 1) begin
      fail_now($sformatf("memory granted %0d requests for one stalled miss", grant_cnt - g0));
    end
    // Filled during the stall, so reported as a hit
    @(posedge clk_i);
    #1;
    pipe_ready_i = 1'b1;
    @(negedge clk_i);
    check_bit("res_valid_o", res_valid_o, 1'b1);
    check_bit("res_miss_o", res_miss_o, 1'b0);
    check_blk("res_blk_o", res_blk_o, exp_blk(q));
    gnt_delay = 1;
    rsp_delay = 2;
    filled_q.push_back(p);
    filled_q.push_back(q);
  endtask

  task automatic flush_invalidates();
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    expect_sweep();
    foreach (filled_q[i]) begin
      expect_fetch(filled_q[i], 1'b0, 1'b1);
    end
  endtask

  // ==========================================================================
  // Main sequence and watchdog
  // ==========================================================================

  initial begin
    void'($urandom(32'hb056));
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    flush_i        = 1'b0;
    req_valid_i    = 1'b0;
    req_addr_i     = '0;
    req_uncached_i = 1'b0;
    pipe_ready_i   = 1'b1;
    gnt_delay      = 1;
    rsp_delay      = 2;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    expect_sweep();
    first_fetch_miss_then_hit();
    stream_hits();
    plru_replacement();
    uncached_bypass();
    backpressure_slow_grant();
    flush_invalidates();
    $display("TEST PASSED");
    $finish;
  end

  initial begin
    #(RUN_LIMIT);
    $display("ERROR at %0t: watchdog expired before the tests finished", $time);
    $display("TEST FAILED");
    $fatal(1, "Watchdog timeout");
  end

endmodule
